//--- files.f
src/exe_pkg.sv
src/alu.sv
src/branch_ctrl.sv
src/execute.sv
src/mem_access.sv
src/exe_mem_top.sv
verif/tb_clock.sv
verif/exe_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute/memory testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/10ps -f files.f \
    --top-module exe_mem_tb -Mdir "$build_dir" -o exe_mem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/exe_mem_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TESTS FAILED" "$log_file"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- verif/exe_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exe_mem_tb;

    import exe_pkg::*;

    localparam int alu_samples = 6;
    localparam int stream_len = 700;
    // about twice the cycles the whole sequence takes
    localparam int timeout_cycles = 2000;

    logic                  clk;
    logic                  rst_n;
    logic [xlen-1:0]       next_pc_exe;
    logic [xlen-1:0]       reg1;
    logic [xlen-1:0]       reg2;
    logic [xlen-1:0]       imm;
    logic [bj_w-1:0]       bj_inst_exe;
    logic [alu_op_w-1:0]   alu_op_exe;
    logic [wb_sel_w-1:0]   wb_sel_exe;
    logic [width_w-1:0]    read_width_exe;
    logic [reg_addr_w-1:0] wrt_dst_exe;
    logic                  mem_wrt_en_exe;
    logic                  reg_wrt_en_exe;
    logic                  read_unsigned_exe;
    logic                  rd_en_exe;
    logic                  jalr_exe;
    logic                  data_sel_exe;
    logic                  branch;
    logic [xlen-1:0]       branch_pc;
    logic                  reg_wrt_en_wb;
    logic [reg_addr_w-1:0] wrt_dst_wb;
    logic [xlen-1:0]       wb_data;

    integer seed;
    int     cycles = 0;

    // expected writeback of each issued slot, oldest first
    logic                  exp_en_q [$];
    logic [reg_addr_w-1:0] exp_dst_q [$];
    logic [xlen-1:0]       exp_data_q [$];

    // byte image of the data memory
    logic [7:0]      ref_mem [dmem_words * 4];
    logic [bj_w-1:0] bj_codes [9];

    tb_clock clk_gen (
        .clk (clk)
    );

    exe_mem_top exe_mem_top_inst (.*);

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [reg_addr_w-1:0] got,
                             input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests were still running after %0d cycles", cycles);
            abort_run();
        end
    end

    function automatic logic [xlen-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [reg_addr_w-1:0] rand_dst();
        logic [xlen-1:0] r;
        r = $random(seed);
        return r[reg_addr_w-1:0];
    endfunction

    function automatic logic [xlen-1:0] ref_alu(input logic [alu_op_w-1:0] op,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [4:0]      sh;
        logic [xlen-1:0] r;
        sh = b[4:0];
        case (op[2:0])
            alu_add: r = op[3] ? a - b : a + b;
            alu_sll: r = a << sh;
            alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_xor: r = a ^ b;
            alu_srl: begin
                r = a >> sh;
                // sra refills the vacated top bits with the sign
                if (op[3] && a[xlen-1]) begin
                    r = r | ~({xlen{1'b1}} >> sh);
                end
            end
            alu_or: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic ref_branch(input logic [bj_w-1:0] bj, input logic [xlen-1:0] a,
                                        input logic [xlen-1:0] b);
        case (bj)
            bj_jal, bj_jalr: return 1'b1;
            bj_beq: return a == b;
            bj_bne: return a != b;
            bj_blt: return $signed(a) < $signed(b);
            bj_bge: return $signed(a) >= $signed(b);
            bj_bltu: return a < b;
            bj_bgeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic store_ref(input logic [xlen-1:0] addr, input logic [width_w-1:0] width,
                             input logic [xlen-1:0] data);
        int b;
        int n;
        b = int'(addr[dmem_aw+1:0]);
        n = (width == width_byte) ? 1 : (width == width_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[b + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [xlen-1:0] load_ref(input logic [xlen-1:0] addr,
                                                 input logic [width_w-1:0] width,
                                                 input logic unsgn);
        int              b;
        logic [xlen-1:0] v;
        b = int'(addr[dmem_aw+1:0]);
        v = {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
        if (width == width_byte) begin
            v = {{(xlen - 8){1'b0}}, ref_mem[b]};
            if (!unsgn && ref_mem[b][7]) begin
                v[xlen-1:8] = '1;
            end
        end else if (width == width_half) begin
            v = {{(xlen - 16){1'b0}}, ref_mem[b + 1], ref_mem[b]};
            if (!unsgn && ref_mem[b + 1][7]) begin
                v[xlen-1:16] = '1;
            end
        end
        return v;
    endfunction

    task automatic clear_slot();
        next_pc_exe = '0;
        reg1 = '0;
        reg2 = '0;
        imm = '0;
        bj_inst_exe = bj_none;
        alu_op_exe = '0;
        wb_sel_exe = wb_alu;
        read_width_exe = width_word;
        wrt_dst_exe = '0;
        mem_wrt_en_exe = 1'b0;
        reg_wrt_en_exe = 1'b0;
        read_unsigned_exe = 1'b0;
        rd_en_exe = 1'b0;
        jalr_exe = 1'b0;
        data_sel_exe = 1'b0;
    endtask

    // clocks in the slot on the inputs and checks the one issued two edges before
    task automatic clock_slot(input logic en, input logic [reg_addr_w-1:0] dst,
                              input logic [xlen-1:0] data);
        exp_en_q.push_back(en);
        exp_dst_q.push_back(dst);
        exp_data_q.push_back(data);
        @(posedge clk);
        @(negedge clk);
        if (exp_en_q.size() == 2) begin
            check_bit("reg_wrt_en_wb", reg_wrt_en_wb, exp_en_q[0]);
            if (exp_en_q[0]) begin
                check_reg("wrt_dst_wb", wrt_dst_wb, exp_dst_q[0]);
                check_word("wb_data", wb_data, exp_data_q[0]);
            end
            void'(exp_en_q.pop_front());
            void'(exp_dst_q.pop_front());
            void'(exp_data_q.pop_front());
        end
        clear_slot();
    endtask

    task automatic flush_pipe();
        repeat (2) clock_slot(1'b0, '0, '0);
    endtask

    task automatic issue_alu(input logic [alu_op_w-1:0] op, input logic use_imm);
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
        logic [reg_addr_w-1:0] dst;
        a = rand_word();
        b = rand_word();
        dst = rand_dst();
        reg1 = a;
        reg2 = b;
        imm = rand_word();
        if (use_imm) begin
            b = {{20{imm[11]}}, imm[11:0]};
            imm = b;
        end
        data_sel_exe = use_imm;
        alu_op_exe = op;
        next_pc_exe = rand_word();
        wrt_dst_exe = dst;
        reg_wrt_en_exe = 1'b1;
        clock_slot(1'b1, dst, ref_alu(op, a, b));
    endtask

    task automatic alu_ops();
        for (int f = 0; f < 16; f++) begin
            for (int s = 0; s < 2 * alu_samples; s++) begin
                issue_alu(f[alu_op_w-1:0], s % 2 == 1);
            end
        end
        flush_pipe();
    endtask

    task automatic alu_stream();
        logic [xlen-1:0] r;
        for (int i = 0; i < stream_len; i++) begin
            r = rand_word();
            issue_alu(r[alu_op_w-1:0], r[4]);
        end
        flush_pipe();
    endtask

    task automatic branch_decisions();
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
        logic [xlen-1:0]       r;
        logic [reg_addr_w-1:0] dst;
        logic                  link;
        bj_codes = '{bj_none, bj_jal, bj_jalr, bj_beq, bj_bne, bj_blt, bj_bge, bj_bltu, bj_bgeu};
        for (int c = 0; c < 9; c++) begin
            for (int k = 0; k < 6; k++) begin
                a = rand_word();
                b = rand_word();
                case (k)
                    1: b = a;
                    2: begin
                        a = 32'h8000_0000;
                        b = 32'h7fff_ffff;
                    end
                    3: begin
                        a = 32'hffff_ffff;
                        b = '0;
                    end
                    4: begin
                        a = '0;
                        b = 32'hffff_ffff;
                    end
                    default: ;
                endcase
                r = rand_word();
                dst = rand_dst();
                link = bj_codes[c] == bj_jal || bj_codes[c] == bj_jalr;
                reg1 = a;
                reg2 = b;
                imm = {{19{r[12]}}, r[12:1], 1'b0};
                next_pc_exe = rand_word();
                bj_inst_exe = bj_codes[c];
                jalr_exe = bj_codes[c] == bj_jalr;
                // jumps write the return address
                wb_sel_exe = link ? wb_pc : wb_alu;
                reg_wrt_en_exe = link;
                wrt_dst_exe = dst;
                #1;
                check_bit("branch", branch, ref_branch(bj_codes[c], a, b));
                check_word("branch_pc", branch_pc,
                           (bj_codes[c] == bj_jalr ? a : next_pc_exe) + imm);
                clock_slot(link, dst, next_pc_exe);
            end
        end
        flush_pipe();
    endtask

    task automatic issue_store(input logic [xlen-1:0] addr, input logic [width_w-1:0] width,
                               input logic [xlen-1:0] data);
        reg1 = {addr[xlen-1:2], 2'b00};
        imm = {{(xlen - 2){1'b0}}, addr[1:0]};
        data_sel_exe = 1'b1;
        alu_op_exe = {1'b0, alu_add};
        reg2 = data;
        read_width_exe = width;
        mem_wrt_en_exe = 1'b1;
        store_ref(addr, width, data);
        clock_slot(1'b0, '0, '0);
    endtask

    task automatic issue_load(input logic [xlen-1:0] addr, input logic [width_w-1:0] width,
                              input logic unsgn);
        logic [reg_addr_w-1:0] dst;
        dst = rand_dst();
        reg1 = {addr[xlen-1:2], 2'b00};
        imm = {{(xlen - 2){1'b0}}, addr[1:0]};
        reg2 = rand_word();
        data_sel_exe = 1'b1;
        alu_op_exe = {1'b0, alu_add};
        read_width_exe = width;
        read_unsigned_exe = unsgn;
        rd_en_exe = 1'b1;
        wb_sel_exe = wb_mem;
        reg_wrt_en_exe = 1'b1;
        wrt_dst_exe = dst;
        clock_slot(1'b1, dst, load_ref(addr, width, unsgn));
    endtask

    task automatic load_every_view(input logic [xlen-1:0] base);
        issue_load(base, width_word, 1'b0);
        for (int off = 0; off < 4; off++) begin
            issue_load(base + off, width_byte, 1'b0);
            issue_load(base + off, width_byte, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_load(base + off, width_half, 1'b0);
            issue_load(base + off, width_half, 1'b1);
        end
    endtask

    task automatic load_store();
        logic [xlen-1:0] r;
        issue_store(32'h0000_0040, width_word, rand_word() | 32'h8000_8080);
        load_every_view(32'h0000_0040);
        // narrow stores fill a second word, each read back the very next cycle
        r = rand_word();
        issue_store(32'h0000_0080, width_byte, {r[xlen-1:8], 8'h9c});
        issue_load(32'h0000_0080, width_byte, 1'b0);
        issue_store(32'h0000_0081, width_byte, {r[xlen-1:8], 8'h5a});
        issue_load(32'h0000_0081, width_byte, 1'b0);
        issue_store(32'h0000_0082, width_half, {r[xlen-1:16], 16'hf0e1});
        issue_load(32'h0000_0082, width_half, 1'b0);
        load_every_view(32'h0000_0080);
        issue_store(32'h0000_0043, width_byte, rand_word());
        issue_store(32'h0000_0040, width_half, rand_word());
        load_every_view(32'h0000_0040);
        flush_pipe();
    endtask

    initial begin
        seed = 32'h4dd02dfd;
        rst_n = 1'b0;
        clear_slot();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("reg_wrt_en_wb", reg_wrt_en_wb, 1'b0);
        // bubbles only, nothing may be written back
        repeat (3) clock_slot(1'b0, '0, '0);
        alu_ops();
        branch_decisions();
        load_store();
        alu_stream();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period
    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- src/exe_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module exe_mem_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [exe_pkg::xlen-1:0]       next_pc_exe,
    input  wire  [exe_pkg::xlen-1:0]       reg1,
    input  wire  [exe_pkg::xlen-1:0]       reg2,
    input  wire  [exe_pkg::xlen-1:0]       imm,
    input  wire  [exe_pkg::bj_w-1:0]       bj_inst_exe,
    input  wire  [exe_pkg::alu_op_w-1:0]   alu_op_exe,
    input  wire  [exe_pkg::wb_sel_w-1:0]   wb_sel_exe,
    input  wire  [exe_pkg::width_w-1:0]    read_width_exe,
    input  wire  [exe_pkg::reg_addr_w-1:0] wrt_dst_exe,
    input  wire                            mem_wrt_en_exe,
    input  wire                            reg_wrt_en_exe,
    input  wire                            read_unsigned_exe,
    input  wire                            rd_en_exe,
    input  wire                            jalr_exe,
    input  wire                            data_sel_exe,
    output logic                           branch,
    output logic [exe_pkg::xlen-1:0]       branch_pc,
    output logic                           reg_wrt_en_wb,
    output logic [exe_pkg::reg_addr_w-1:0] wrt_dst_wb,
    output logic [exe_pkg::xlen-1:0]       wb_data
);

    import exe_pkg::*;

    logic [xlen-1:0]       next_pc_mem;
    logic [xlen-1:0]       write_data_mem;
    logic [xlen-1:0]       alu_result_mem;
    logic [wb_sel_w-1:0]   wb_sel_mem;
    logic [width_w-1:0]    read_width_mem;
    logic [reg_addr_w-1:0] wrt_dst_mem;
    logic                  mem_wrt_en_mem;
    logic                  reg_wrt_en_mem;
    logic                  read_unsigned_mem;
    logic                  rd_en_mem;

    execute exe_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .next_pc_exe       (next_pc_exe),
        .reg1              (reg1),
        .reg2              (reg2),
        .imm               (imm),
        .bj_inst_exe       (bj_inst_exe),
        .alu_op_exe        (alu_op_exe),
        .wb_sel_exe        (wb_sel_exe),
        .read_width_exe    (read_width_exe),
        .wrt_dst_exe       (wrt_dst_exe),
        .mem_wrt_en_exe    (mem_wrt_en_exe),
        .reg_wrt_en_exe    (reg_wrt_en_exe),
        .read_unsigned_exe (read_unsigned_exe),
        .rd_en_exe         (rd_en_exe),
        .jalr_exe          (jalr_exe),
        .data_sel_exe      (data_sel_exe),
        .next_pc_mem       (next_pc_mem),
        .write_data_mem    (write_data_mem),
        .alu_result_mem    (alu_result_mem),
        .branch_pc         (branch_pc),
        .wb_sel_mem        (wb_sel_mem),
        .read_width_mem    (read_width_mem),
        .wrt_dst_mem       (wrt_dst_mem),
        .mem_wrt_en_mem    (mem_wrt_en_mem),
        .reg_wrt_en_mem    (reg_wrt_en_mem),
        .read_unsigned_mem (read_unsigned_mem),
        .rd_en_mem         (rd_en_mem),
        .branch            (branch)
    );

    mem_access mem_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .next_pc_mem       (next_pc_mem),
        .write_data_mem    (write_data_mem),
        .alu_result_mem    (alu_result_mem),
        .wb_sel_mem        (wb_sel_mem),
        .read_width_mem    (read_width_mem),
        .wrt_dst_mem       (wrt_dst_mem),
        .mem_wrt_en_mem    (mem_wrt_en_mem),
        .reg_wrt_en_mem    (reg_wrt_en_mem),
        .read_unsigned_mem (read_unsigned_mem),
        .rd_en_mem         (rd_en_mem),
        .reg_wrt_en_wb     (reg_wrt_en_wb),
        .wrt_dst_wb        (wrt_dst_wb),
        .wb_data           (wb_data)
    );

endmodule

`default_nettype wire

//--- src/mem_access.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [exe_pkg::xlen-1:0]       next_pc_mem,
    input  wire  [exe_pkg::xlen-1:0]       write_data_mem,
    input  wire  [exe_pkg::xlen-1:0]       alu_result_mem,
    input  wire  [exe_pkg::wb_sel_w-1:0]   wb_sel_mem,
    input  wire  [exe_pkg::width_w-1:0]    read_width_mem,
    input  wire  [exe_pkg::reg_addr_w-1:0] wrt_dst_mem,
    input  wire                            mem_wrt_en_mem,
    input  wire                            reg_wrt_en_mem,
    input  wire                            read_unsigned_mem,
    input  wire                            rd_en_mem,
    output logic                           reg_wrt_en_wb,
    output logic [exe_pkg::reg_addr_w-1:0] wrt_dst_wb,
    output logic [exe_pkg::xlen-1:0]       wb_data
);

    import exe_pkg::*;

    logic [xlen-1:0]    dmem [dmem_words];
    logic [dmem_aw-1:0] word_idx;
    logic [1:0]         byte_off;
    logic [3:0]         byte_en;
    logic [xlen-1:0]    store_data;
    logic [xlen-1:0]    read_word;
    logic [7:0]         read_byte;
    logic [15:0]        read_half;
    logic [xlen-1:0]    load_data;
    logic [xlen-1:0]    wb_next;

    assign word_idx = alu_result_mem[dmem_aw + 1:2];
    assign byte_off = alu_result_mem[1:0];

    // narrow stores are replicated so each lane sees the same bits
    always_comb begin
        case (read_width_mem)
            width_byte: begin
                byte_en = 4'b0001 << byte_off;
                store_data = {4{write_data_mem[7:0]}};
            end
            width_half: begin
                byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
                store_data = {2{write_data_mem[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                store_data = write_data_mem;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mem_wrt_en_mem && byte_en[i]) begin
                dmem[word_idx][i*8 +: 8] <= store_data[i*8 +: 8];
            end
        end
    end

    // read is combinational, so a store in the previous cycle is visible
    assign read_word = dmem[word_idx];
    assign read_byte = read_word[byte_off*8 +: 8];
    assign read_half = byte_off[1] ? read_word[31:16] : read_word[15:0];

    always_comb begin
        load_data = '0;
        if (rd_en_mem) begin
            case (read_width_mem)
                width_byte: begin
                    load_data = {{(xlen - 8){read_byte[7] & !read_unsigned_mem}}, read_byte};
                end
                width_half: begin
                    load_data = {{(xlen - 16){read_half[15] & !read_unsigned_mem}}, read_half};
                end
                default: begin
                    load_data = read_word;
                end
            endcase
        end
    end

    always_comb begin
        case (wb_sel_mem)
            wb_mem: begin
                wb_next = load_data;
            end
            wb_pc: begin
                wb_next = next_pc_mem;
            end
            default: begin
                wb_next = alu_result_mem;
            end
        endcase
    end

    // mem/wb boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wrt_en_wb <= 1'b0;
            wrt_dst_wb <= '0;
            wb_data <= '0;
        end else begin
            reg_wrt_en_wb <= reg_wrt_en_mem;
            wrt_dst_wb <= wrt_dst_mem;
            wb_data <= wb_next;
        end
    end

endmodule

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [exe_pkg::xlen-1:0]       next_pc_exe,
    input  wire  [exe_pkg::xlen-1:0]       reg1,
    input  wire  [exe_pkg::xlen-1:0]       reg2,
    input  wire  [exe_pkg::xlen-1:0]       imm,
    input  wire  [exe_pkg::bj_w-1:0]       bj_inst_exe,
    input  wire  [exe_pkg::alu_op_w-1:0]   alu_op_exe,
    input  wire  [exe_pkg::wb_sel_w-1:0]   wb_sel_exe,
    input  wire  [exe_pkg::width_w-1:0]    read_width_exe,
    input  wire  [exe_pkg::reg_addr_w-1:0] wrt_dst_exe,
    input  wire                            mem_wrt_en_exe,
    input  wire                            reg_wrt_en_exe,
    input  wire                            read_unsigned_exe,
    input  wire                            rd_en_exe,
    input  wire                            jalr_exe,
    input  wire                            data_sel_exe,
    output logic [exe_pkg::xlen-1:0]       next_pc_mem,
    output logic [exe_pkg::xlen-1:0]       write_data_mem,
    output logic [exe_pkg::xlen-1:0]       alu_result_mem,
    output logic [exe_pkg::xlen-1:0]       branch_pc,
    output logic [exe_pkg::wb_sel_w-1:0]   wb_sel_mem,
    output logic [exe_pkg::width_w-1:0]    read_width_mem,
    output logic [exe_pkg::reg_addr_w-1:0] wrt_dst_mem,
    output logic                           mem_wrt_en_mem,
    output logic                           reg_wrt_en_mem,
    output logic                           read_unsigned_mem,
    output logic                           rd_en_mem,
    output logic                           branch
);

    import exe_pkg::*;

    logic [xlen-1:0] alu_in_b;
    logic [xlen-1:0] branch_base;
    logic [xlen-1:0] alu_result_exe;

    // immediate forms take the second operand from imm
    assign alu_in_b = data_sel_exe ? imm : reg2;

    // jalr is register relative, everything else pc relative
    assign branch_base = jalr_exe ? reg1 : next_pc_exe;
    assign branch_pc = branch_base + imm;

    alu exe_alu (
        .in_a       (reg1),
        .in_b       (alu_in_b),
        .alu_op     (alu_op_exe[2:0]),
        .option_bit (alu_op_exe[3]),
        .result     (alu_result_exe)
    );

    branch_ctrl exe_branch_ctrl (
        .bj_inst (bj_inst_exe),
        .in_a    (reg1),
        .in_b    (reg2),
        .branch  (branch)
    );

    // ex/mem boundary, advances every clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc_mem <= '0;
            write_data_mem <= '0;
            alu_result_mem <= '0;
            wb_sel_mem <= '0;
            read_width_mem <= '0;
            wrt_dst_mem <= '0;
            mem_wrt_en_mem <= 1'b0;
            reg_wrt_en_mem <= 1'b0;
            read_unsigned_mem <= 1'b0;
            rd_en_mem <= 1'b0;
        end else begin
            next_pc_mem <= next_pc_exe;
            write_data_mem <= reg2;
            alu_result_mem <= alu_result_exe;
            wb_sel_mem <= wb_sel_exe;
            read_width_mem <= read_width_exe;
            wrt_dst_mem <= wrt_dst_exe;
            mem_wrt_en_mem <= mem_wrt_en_exe;
            reg_wrt_en_mem <= reg_wrt_en_exe;
            read_unsigned_mem <= read_unsigned_exe;
            rd_en_mem <= rd_en_exe;
        end
    end

endmodule

`default_nettype wire

//--- src/branch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module branch_ctrl (
    input  wire  [exe_pkg::bj_w-1:0] bj_inst,
    input  wire  [exe_pkg::xlen-1:0] in_a,
    input  wire  [exe_pkg::xlen-1:0] in_b,
    output logic                     branch
);

    import exe_pkg::*;

    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    assign equal = in_a == in_b;
    assign lt_signed = $signed(in_a) < $signed(in_b);
    assign lt_unsigned = in_a < in_b;

    always_comb begin
        case (bj_inst)
            // jumps are always taken
            bj_jal, bj_jalr: begin
                branch = 1'b1;
            end
            bj_beq: begin
                branch = equal;
            end
            bj_bne: begin
                branch = !equal;
            end
            bj_blt: begin
                branch = lt_signed;
            end
            bj_bge: begin
                branch = !lt_signed;
            end
            bj_bltu: begin
                branch = lt_unsigned;
            end
            bj_bgeu: begin
                branch = !lt_unsigned;
            end
            default: begin
                branch = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire  [exe_pkg::xlen-1:0] in_a,
    input  wire  [exe_pkg::xlen-1:0] in_b,
    input  wire  [2:0]               alu_op,
    input  wire                      option_bit,
    output logic [exe_pkg::xlen-1:0] result
);

    import exe_pkg::*;

    logic [4:0]      shamt;
    logic [xlen-1:0] b_operand;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] srl_result;
    logic [xlen-1:0] sra_result;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt = in_b[4:0];

    // subtract is add of the inverted operand with a carry-in
    assign b_operand = option_bit ? ~in_b : in_b;
    assign sum = in_a + b_operand + {{(xlen - 1){1'b0}}, option_bit};

    assign lt_signed = $signed(in_a) < $signed(in_b);
    assign lt_unsigned = in_a < in_b;

    assign srl_result = in_a >> shamt;
    // kept on its own so the shift stays signed
    assign sra_result = $signed(in_a) >>> shamt;

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = sum;
            end
            alu_sll: begin
                result = in_a << shamt;
            end
            alu_slt: begin
                result = {{(xlen - 1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen - 1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result = in_a ^ in_b;
            end
            alu_srl: begin
                result = option_bit ? sra_result : srl_result;
            end
            alu_or: begin
                result = in_a | in_b;
            end
            default: begin
                result = in_a & in_b;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/exe_pkg.sv
`default_nettype none

package exe_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // destination register index width
    localparam int reg_addr_w = 5;

    // control field widths
    localparam int alu_op_w = 4;
    localparam int bj_w = 4;
    localparam int wb_sel_w = 2;
    localparam int width_w = 2;

    // alu function, low three bits of alu_op
    // bit 3 is the option bit: sub instead of add, sra instead of srl
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sll = 3'd1;
    localparam logic [2:0] alu_slt = 3'd2;
    localparam logic [2:0] alu_sltu = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;
    localparam logic [2:0] alu_srl = 3'd5;
    localparam logic [2:0] alu_or = 3'd6;
    localparam logic [2:0] alu_and = 3'd7;

    // branch and jump kinds
    localparam logic [bj_w-1:0] bj_none = 4'd0;
    localparam logic [bj_w-1:0] bj_jal = 4'd1;
    localparam logic [bj_w-1:0] bj_jalr = 4'd2;
    localparam logic [bj_w-1:0] bj_beq = 4'd8;
    localparam logic [bj_w-1:0] bj_bne = 4'd9;
    localparam logic [bj_w-1:0] bj_blt = 4'd12;
    localparam logic [bj_w-1:0] bj_bge = 4'd13;
    localparam logic [bj_w-1:0] bj_bltu = 4'd14;
    localparam logic [bj_w-1:0] bj_bgeu = 4'd15;

    // writeback source
    localparam logic [wb_sel_w-1:0] wb_alu = 2'd0;
    localparam logic [wb_sel_w-1:0] wb_mem = 2'd1;
    localparam logic [wb_sel_w-1:0] wb_pc = 2'd2;

    // access size, shared by loads and stores
    localparam logic [width_w-1:0] width_byte = 2'd0;
    localparam logic [width_w-1:0] width_half = 2'd1;
    localparam logic [width_w-1:0] width_word = 2'd2;

    // data memory, word addressed by address bits [dmem_aw+1:2]
    localparam int dmem_words = 256;
    localparam int dmem_aw = $clog2(dmem_words);

endpackage

`default_nettype wire
